// ==== hw/xcvr_csr_pkg.sv ====
package xcvr_csr_pkg;

  // bus and counter widths
  localparam int csr_addr_width = 10;
  localparam int csr_data_width = 8;
  localparam int count_width    = 50;
  localparam int count_bytes    = 7;
  // flops per synchronizer chain
  localparam int sync_stages    = 3;

  // value returned for addresses no block claims
  localparam logic [csr_data_width-1:0] rd_unused = 8'h00;

  // capability bytes, fixed for this build
  localparam logic [csr_data_width-1:0] cap_user_id     = 8'h5a;
  localparam logic [csr_data_width-1:0] cap_status_en   = 8'd1;
  localparam logic [csr_data_width-1:0] cap_control_en  = 8'd1;
  localparam logic [csr_data_width-1:0] cap_channels    = 8'd1;
  localparam logic [csr_data_width-1:0] cap_channel_num = 8'd0;
  // 3 means duplex, 2 tx only, 1 rx only
  localparam logic [csr_data_width-1:0] cap_duplex      = 8'd3;
  localparam logic [csr_data_width-1:0] cap_prbs_en     = 8'd1;
  // odi logic is not built
  localparam logic [csr_data_width-1:0] cap_odi_en      = 8'd0;

  // capability addresses
  localparam logic [csr_addr_width-1:0] addr_id            = 10'h000;
  localparam logic [csr_addr_width-1:0] addr_status_en     = 10'h001;
  localparam logic [csr_addr_width-1:0] addr_control_en    = 10'h002;
  localparam logic [csr_addr_width-1:0] addr_nat_chnls     = 10'h003;
  localparam logic [csr_addr_width-1:0] addr_nat_chnl_num  = 10'h004;
  localparam logic [csr_addr_width-1:0] addr_nat_duplex    = 10'h005;
  localparam logic [csr_addr_width-1:0] addr_nat_prbs_en   = 10'h006;
  localparam logic [csr_addr_width-1:0] addr_nat_odi_en    = 10'h007;

  // prbs control and the two 7-byte count windows
  localparam logic [csr_addr_width-1:0] addr_prbs_ctrl     = 10'h010;
  localparam logic [csr_addr_width-1:0] addr_prbs_err_base = 10'h011;
  localparam logic [csr_addr_width-1:0] addr_prbs_bit_base = 10'h018;

  // status and channel control
  localparam logic [csr_addr_width-1:0] addr_rd_ltr        = 10'h020;
  localparam logic [csr_addr_width-1:0] addr_cal_busy      = 10'h021;
  localparam logic [csr_addr_width-1:0] addr_set_ltr       = 10'h022;
  localparam logic [csr_addr_width-1:0] addr_lpbk          = 10'h023;
  localparam logic [csr_addr_width-1:0] addr_chnl_reset    = 10'h024;

  // lock status byte
  localparam int off_rd_ltr      = 0;
  localparam int off_rd_ltd      = 1;

  // calibration busy byte, bit 3 is a hole
  localparam int off_tx_cal_busy = 0;
  localparam int off_rx_cal_busy = 1;
  localparam int off_avmm_busy   = 2;
  localparam int off_tx_cal_mask = 4;
  localparam int off_rx_cal_mask = 5;

  // lock control byte
  localparam int off_set_ltr     = 0;
  localparam int off_set_ltd     = 1;
  localparam int off_set_ltr_ovr = 2;
  localparam int off_set_ltd_ovr = 3;

  // loopback byte
  localparam int off_lpbk        = 0;

  // channel reset byte, overrides in the upper nibble
  localparam int off_rx_ana      = 0;
  localparam int off_rx_dig      = 1;
  localparam int off_tx_ana      = 2;
  localparam int off_tx_dig      = 3;
  localparam int off_rx_ana_ovr  = off_rx_ana + 4;
  localparam int off_rx_dig_ovr  = off_rx_dig + 4;
  localparam int off_tx_ana_ovr  = off_tx_ana + 4;
  localparam int off_tx_dig_ovr  = off_tx_dig + 4;

  // prbs control byte
  localparam int off_prbs_en     = 0;
  localparam int off_prbs_reset  = 1;
  localparam int off_prbs_snap   = 2;
  localparam int off_prbs_done   = 3;

endpackage

// ==== hw/resync_chain.sv ====
`timescale 1ns/1ps

module resync_chain #(
  parameter int width  = 1,
  parameter int stages = xcvr_csr_pkg::sync_stages
) (
  input  logic             avmm_clk,
  input  logic             avmm_reset,
  input  logic [width-1:0] d,
  output logic [width-1:0] q
);

  // stage 0 samples the asynchronous input
  logic [width-1:0] sync_q [stages];

  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      for (int i = 0; i < stages; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= d;
      // shift toward the output
      for (int i = 1; i < stages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign q = sync_q[stages-1];

endmodule

// ==== hw/channel_status_regs.sv ====
`timescale 1ns/1ps

module channel_status_regs (
  input  logic                                    avmm_clk,
  input  logic                                    avmm_reset,
  input  logic [xcvr_csr_pkg::csr_addr_width-1:0] avmm_address,
  input  logic [xcvr_csr_pkg::csr_data_width-1:0] avmm_writedata,
  input  logic                                    avmm_write,
  input  logic                                    rx_is_lockedtodata,
  input  logic                                    rx_is_lockedtoref,
  input  logic                                    tx_cal_busy,
  input  logic                                    rx_cal_busy,
  input  logic                                    avmm_busy,
  output logic                                    csr_tx_cal_busy_mask,
  output logic                                    csr_rx_cal_busy_mask,
  output logic [xcvr_csr_pkg::csr_data_width-1:0] rd_data
);

  import xcvr_csr_pkg::*;

  logic ltr_sync;
  logic ltd_sync;
  logic tx_cal_sync;
  logic rx_cal_sync;
  logic avmm_busy_q;

  // lock indications come from the cdr clock domain
  resync_chain #(.width(2)) u_lock_sync (
    .avmm_clk   (avmm_clk),
    .avmm_reset (avmm_reset),
    .d          ({rx_is_lockedtodata, rx_is_lockedtoref}),
    .q          ({ltd_sync, ltr_sync})
  );

  // calibration busy comes from the calibration engine
  resync_chain #(.width(2)) u_cal_sync (
    .avmm_clk   (avmm_clk),
    .avmm_reset (avmm_reset),
    .d          ({rx_cal_busy, tx_cal_busy}),
    .q          ({rx_cal_sync, tx_cal_sync})
  );

  // avmm_busy is already in this domain, one flop is enough
  // masks come up set so cal busy is passed on by default
  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      avmm_busy_q          <= 1'b0;
      csr_tx_cal_busy_mask <= 1'b1;
      csr_rx_cal_busy_mask <= 1'b1;
    end else begin
      avmm_busy_q <= avmm_busy;
      if (avmm_write && avmm_address == addr_cal_busy) begin
        csr_tx_cal_busy_mask <= avmm_writedata[off_tx_cal_mask];
        csr_rx_cal_busy_mask <= avmm_writedata[off_rx_cal_mask];
      end
    end
  end

  // read mux, zero when neither status address is selected
  always_comb begin
    rd_data = rd_unused;
    if (avmm_address == addr_rd_ltr) begin
      rd_data              = '0;
      rd_data[off_rd_ltr]  = ltr_sync;
      rd_data[off_rd_ltd]  = ltd_sync;
    end else if (avmm_address == addr_cal_busy) begin
      rd_data                  = '0;
      rd_data[off_tx_cal_busy] = tx_cal_sync;
      rd_data[off_rx_cal_busy] = rx_cal_sync;
      rd_data[off_avmm_busy]   = avmm_busy_q;
      rd_data[off_tx_cal_mask] = csr_tx_cal_busy_mask;
      rd_data[off_rx_cal_mask] = csr_rx_cal_busy_mask;
    end
  end

endmodule

// ==== hw/channel_ctrl_regs.sv ====
`timescale 1ns/1ps

module channel_ctrl_regs (
  input  logic                                    avmm_clk,
  input  logic                                    avmm_reset,
  input  logic [xcvr_csr_pkg::csr_addr_width-1:0] avmm_address,
  input  logic [xcvr_csr_pkg::csr_data_width-1:0] avmm_writedata,
  input  logic                                    avmm_write,
  input  logic                                    set_rx_locktoref,
  input  logic                                    set_rx_locktodata,
  input  logic                                    serial_loopback,
  input  logic                                    rx_analogreset,
  input  logic                                    rx_digitalreset,
  input  logic                                    tx_analogreset,
  input  logic                                    tx_digitalreset,
  output logic                                    csr_set_lock_to_ref,
  output logic                                    csr_set_lock_to_data,
  output logic                                    csr_en_loopback,
  output logic                                    csr_rx_analogreset,
  output logic                                    csr_rx_digitalreset,
  output logic                                    csr_tx_analogreset,
  output logic                                    csr_tx_digitalreset,
  output logic [xcvr_csr_pkg::csr_data_width-1:0] rd_data
);

  import xcvr_csr_pkg::*;

  // lock value and override bits, upper nibble of the byte unused
  logic [3:0]                lock_q;
  logic                      lpbk_q;
  // all eight bits of the reset byte are used
  logic [csr_data_width-1:0] rst_q;

  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      lock_q <= '0;
      lpbk_q <= 1'b0;
      rst_q  <= '0;
    end else if (avmm_write) begin
      if (avmm_address == addr_set_ltr) begin
        lock_q[off_set_ltr]     <= avmm_writedata[off_set_ltr];
        lock_q[off_set_ltd]     <= avmm_writedata[off_set_ltd];
        lock_q[off_set_ltr_ovr] <= avmm_writedata[off_set_ltr_ovr];
        lock_q[off_set_ltd_ovr] <= avmm_writedata[off_set_ltd_ovr];
      end
      if (avmm_address == addr_lpbk) begin
        lpbk_q <= avmm_writedata[off_lpbk];
      end
      if (avmm_address == addr_chnl_reset) begin
        rst_q <= avmm_writedata;
      end
    end
  end

  // override set: register drives the channel, else the input passes through
  assign csr_set_lock_to_ref  = lock_q[off_set_ltr_ovr] ? lock_q[off_set_ltr] : set_rx_locktoref;
  assign csr_set_lock_to_data = lock_q[off_set_ltd_ovr] ? lock_q[off_set_ltd] : set_rx_locktodata;

  // either source can turn serial loopback on
  assign csr_en_loopback = lpbk_q | serial_loopback;

  assign csr_rx_analogreset  = rst_q[off_rx_ana_ovr] ? rst_q[off_rx_ana] : rx_analogreset;
  assign csr_rx_digitalreset = rst_q[off_rx_dig_ovr] ? rst_q[off_rx_dig] : rx_digitalreset;
  assign csr_tx_analogreset  = rst_q[off_tx_ana_ovr] ? rst_q[off_tx_ana] : tx_analogreset;
  assign csr_tx_digitalreset = rst_q[off_tx_dig_ovr] ? rst_q[off_tx_dig] : tx_digitalreset;

  // readback of the stored bytes, other bits zero
  always_comb begin
    rd_data = rd_unused;
    case (avmm_address)
      addr_set_ltr: begin
        rd_data = csr_data_width'(lock_q);
      end
      addr_lpbk: begin
        rd_data           = '0;
        rd_data[off_lpbk] = lpbk_q;
      end
      addr_chnl_reset: begin
        rd_data = rst_q;
      end
      default: begin
        rd_data = rd_unused;
      end
    endcase
  end

endmodule

// ==== hw/prbs_ctrl_regs.sv ====
`timescale 1ns/1ps

module prbs_ctrl_regs (
  input  logic                                    avmm_clk,
  input  logic                                    avmm_reset,
  input  logic [xcvr_csr_pkg::csr_addr_width-1:0] avmm_address,
  input  logic [xcvr_csr_pkg::csr_data_width-1:0] avmm_writedata,
  input  logic                                    avmm_write,
  input  logic [xcvr_csr_pkg::count_width-1:0]    prbs_err,
  input  logic [xcvr_csr_pkg::count_width-1:0]    prbs_bit,
  input  logic                                    prbs_done,
  input  logic                                    rx_prbs_err_clr,
  output logic                                    prbs_count_en,
  output logic                                    prbs_snap,
  output logic                                    prbs_reset,
  output logic [xcvr_csr_pkg::csr_data_width-1:0] rd_data
);

  import xcvr_csr_pkg::*;

  localparam int pad_width = count_bytes * csr_data_width;
  localparam int sel_width = $clog2(count_bytes);

  logic                      prbs_en_q;
  logic                      prbs_reset_q;
  logic                      prbs_snap_q;
  logic                      err_clr_sync;
  logic [pad_width-1:0]      err_pad;
  logic [pad_width-1:0]      bit_pad;
  logic [csr_addr_width-1:0] err_off;
  logic [csr_addr_width-1:0] bit_off;

  // error clear arrives from the rx parallel clock domain
  resync_chain #(.width(1)) u_err_clr_sync (
    .avmm_clk   (avmm_clk),
    .avmm_reset (avmm_reset),
    .d          (rx_prbs_err_clr),
    .q          (err_clr_sync)
  );

  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      prbs_en_q    <= 1'b0;
      prbs_reset_q <= 1'b0;
      prbs_snap_q  <= 1'b0;
    end else if (avmm_write && avmm_address == addr_prbs_ctrl) begin
      prbs_en_q    <= avmm_writedata[off_prbs_en];
      prbs_reset_q <= avmm_writedata[off_prbs_reset];
      prbs_snap_q  <= avmm_writedata[off_prbs_snap];
    end
  end

  assign prbs_count_en = prbs_en_q;
  assign prbs_snap     = prbs_snap_q;
  // software reset or the external clear both restart the counters
  assign prbs_reset    = prbs_reset_q | err_clr_sync;

  // counts widened to whole bytes, top byte zero above bit 49
  assign err_pad = pad_width'(prbs_err);
  assign bit_pad = pad_width'(prbs_bit);
  // byte index inside each 7-byte window
  assign err_off = avmm_address - addr_prbs_err_base;
  assign bit_off = avmm_address - addr_prbs_bit_base;

  always_comb begin
    rd_data = rd_unused;
    if (avmm_address == addr_prbs_ctrl) begin
      rd_data                 = '0;
      rd_data[off_prbs_en]    = prbs_en_q;
      rd_data[off_prbs_reset] = prbs_reset_q;
      rd_data[off_prbs_snap]  = prbs_snap_q;
      rd_data[off_prbs_done]  = prbs_done;
    end else if (err_off < count_bytes) begin
      rd_data = err_pad[err_off[sel_width-1:0]*csr_data_width +: csr_data_width];
    end else if (bit_off < count_bytes) begin
      rd_data = bit_pad[bit_off[sel_width-1:0]*csr_data_width +: csr_data_width];
    end
  end

endmodule

// ==== hw/csr_read_port.sv ====
`timescale 1ns/1ps

module csr_read_port (
  input  logic                                    avmm_clk,
  input  logic                                    avmm_reset,
  input  logic [xcvr_csr_pkg::csr_addr_width-1:0] avmm_address,
  input  logic                                    avmm_read,
  input  logic [xcvr_csr_pkg::csr_data_width-1:0] status_rd,
  input  logic [xcvr_csr_pkg::csr_data_width-1:0] ctrl_rd,
  input  logic [xcvr_csr_pkg::csr_data_width-1:0] prbs_rd,
  output logic [xcvr_csr_pkg::csr_data_width-1:0] avmm_readdata,
  output logic                                    avmm_waitrequest
);

  import xcvr_csr_pkg::*;

  // high in the second cycle of a read, when readdata is good
  logic                      rd_valid;
  logic [csr_data_width-1:0] cap_byte;
  logic [csr_data_width-1:0] rd_merged;

  // first cycle of every read stalls
  assign avmm_waitrequest = avmm_read & ~rd_valid;

  always_comb begin
    case (avmm_address)
      addr_id:           cap_byte = cap_user_id;
      addr_status_en:    cap_byte = cap_status_en;
      addr_control_en:   cap_byte = cap_control_en;
      addr_nat_chnls:    cap_byte = cap_channels;
      addr_nat_chnl_num: cap_byte = cap_channel_num;
      addr_nat_duplex:   cap_byte = cap_duplex;
      addr_nat_prbs_en:  cap_byte = cap_prbs_en;
      addr_nat_odi_en:   cap_byte = cap_odi_en;
      default:           cap_byte = rd_unused;
    endcase
  end

  // each block returns zero off its own addresses so a plain OR merges them
  assign rd_merged = cap_byte | status_rd | ctrl_rd | prbs_rd;

  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      rd_valid      <= 1'b0;
      avmm_readdata <= '0;
    end else if (!avmm_read) begin
      rd_valid      <= 1'b0;
      avmm_readdata <= '0;
    end else begin
      // toggles so back-to-back reads each get a stall cycle
      rd_valid      <= avmm_waitrequest;
      avmm_readdata <= rd_merged;
    end
  end

endmodule

// ==== hw/xcvr_native_csr.sv ====
`timescale 1ns/1ps

module xcvr_native_csr (
  input  logic                                    avmm_clk,
  input  logic                                    avmm_reset,
  input  logic [xcvr_csr_pkg::csr_addr_width-1:0] avmm_address,
  input  logic [xcvr_csr_pkg::csr_data_width-1:0] avmm_writedata,
  input  logic                                    avmm_write,
  input  logic                                    avmm_read,
  output logic [xcvr_csr_pkg::csr_data_width-1:0] avmm_readdata,
  output logic                                    avmm_waitrequest,
  // prbs checker
  input  logic [xcvr_csr_pkg::count_width-1:0]    prbs_err,
  input  logic [xcvr_csr_pkg::count_width-1:0]    prbs_bit,
  input  logic                                    prbs_done,
  output logic                                    prbs_count_en,
  output logic                                    prbs_snap,
  output logic                                    prbs_reset,
  // channel status
  input  logic                                    rx_is_lockedtodata,
  input  logic                                    rx_is_lockedtoref,
  input  logic                                    tx_cal_busy,
  input  logic                                    rx_cal_busy,
  input  logic                                    avmm_busy,
  // controls from the user side
  input  logic                                    rx_prbs_err_clr,
  input  logic                                    set_rx_locktoref,
  input  logic                                    set_rx_locktodata,
  input  logic                                    serial_loopback,
  input  logic                                    rx_analogreset,
  input  logic                                    rx_digitalreset,
  input  logic                                    tx_analogreset,
  input  logic                                    tx_digitalreset,
  // controls toward the channel
  output logic                                    csr_set_lock_to_data,
  output logic                                    csr_set_lock_to_ref,
  output logic                                    csr_en_loopback,
  output logic                                    csr_rx_analogreset,
  output logic                                    csr_rx_digitalreset,
  output logic                                    csr_tx_analogreset,
  output logic                                    csr_tx_digitalreset,
  output logic                                    csr_tx_cal_busy_mask,
  output logic                                    csr_rx_cal_busy_mask
);

  import xcvr_csr_pkg::*;

  // per-block read bytes, zero when the block is not addressed
  logic [csr_data_width-1:0] status_rd;
  logic [csr_data_width-1:0] ctrl_rd;
  logic [csr_data_width-1:0] prbs_rd;

  channel_status_regs u_status (
    .avmm_clk             (avmm_clk),
    .avmm_reset           (avmm_reset),
    .avmm_address         (avmm_address),
    .avmm_writedata       (avmm_writedata),
    .avmm_write           (avmm_write),
    .rx_is_lockedtodata   (rx_is_lockedtodata),
    .rx_is_lockedtoref    (rx_is_lockedtoref),
    .tx_cal_busy          (tx_cal_busy),
    .rx_cal_busy          (rx_cal_busy),
    .avmm_busy            (avmm_busy),
    .csr_tx_cal_busy_mask (csr_tx_cal_busy_mask),
    .csr_rx_cal_busy_mask (csr_rx_cal_busy_mask),
    .rd_data              (status_rd)
  );

  channel_ctrl_regs u_ctrl (
    .avmm_clk             (avmm_clk),
    .avmm_reset           (avmm_reset),
    .avmm_address         (avmm_address),
    .avmm_writedata       (avmm_writedata),
    .avmm_write           (avmm_write),
    .set_rx_locktoref     (set_rx_locktoref),
    .set_rx_locktodata    (set_rx_locktodata),
    .serial_loopback      (serial_loopback),
    .rx_analogreset       (rx_analogreset),
    .rx_digitalreset      (rx_digitalreset),
    .tx_analogreset       (tx_analogreset),
    .tx_digitalreset      (tx_digitalreset),
    .csr_set_lock_to_ref  (csr_set_lock_to_ref),
    .csr_set_lock_to_data (csr_set_lock_to_data),
    .csr_en_loopback      (csr_en_loopback),
    .csr_rx_analogreset   (csr_rx_analogreset),
    .csr_rx_digitalreset  (csr_rx_digitalreset),
    .csr_tx_analogreset   (csr_tx_analogreset),
    .csr_tx_digitalreset  (csr_tx_digitalreset),
    .rd_data              (ctrl_rd)
  );

  prbs_ctrl_regs u_prbs (
    .avmm_clk             (avmm_clk),
    .avmm_reset           (avmm_reset),
    .avmm_address         (avmm_address),
    .avmm_writedata       (avmm_writedata),
    .avmm_write           (avmm_write),
    .prbs_err             (prbs_err),
    .prbs_bit             (prbs_bit),
    .prbs_done            (prbs_done),
    .rx_prbs_err_clr      (rx_prbs_err_clr),
    .prbs_count_en        (prbs_count_en),
    .prbs_snap            (prbs_snap),
    .prbs_reset           (prbs_reset),
    .rd_data              (prbs_rd)
  );

  // capability bytes, merge and the read handshake
  csr_read_port u_read (
    .avmm_clk             (avmm_clk),
    .avmm_reset           (avmm_reset),
    .avmm_address         (avmm_address),
    .avmm_read            (avmm_read),
    .status_rd            (status_rd),
    .ctrl_rd              (ctrl_rd),
    .prbs_rd              (prbs_rd),
    .avmm_readdata        (avmm_readdata),
    .avmm_waitrequest     (avmm_waitrequest)
  );

endmodule

// ==== tests/tb_csr_tasks.svh ====
`ifndef tb_csr_tasks_svh
`define tb_csr_tasks_svh

task automatic check_value(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
  if (actual !== expected) begin
    report_failure($sformatf("FAIL %s expected %02h actual %02h", name, expected, actual));
  end
endtask

// one cycle write, no wait state
task automatic bus_write(input logic [csr_addr_width-1:0] addr, input logic [7:0] data);
  @(negedge avmm_clk);
  avmm_address   = addr;
  avmm_writedata = data;
  avmm_write     = 1'b1;
  @(negedge avmm_clk);
  avmm_write = 1'b0;
endtask

// hold read until waitrequest drops, expect exactly one stall cycle
task automatic bus_read(input string name, input logic [csr_addr_width-1:0] addr,
                        output logic [7:0] data);
  int stall_cycles;
  @(negedge avmm_clk);
  avmm_address = addr;
  avmm_read    = 1'b1;
  // waitrequest is combinational on read, let it settle
  #1;
  stall_cycles = avmm_waitrequest ? 1 : 0;
  @(negedge avmm_clk);
  while (avmm_waitrequest) begin
    stall_cycles++;
    @(negedge avmm_clk);
  end
  data      = avmm_readdata;
  avmm_read = 1'b0;
  check_value({name, " waitrequest cycles"}, 8'd1, 8'(stall_cycles));
endtask

task automatic read_expect(input string name, input logic [csr_addr_width-1:0] addr,
                           input logic [7:0] expected);
  logic [7:0] data;
  bus_read(name, addr, data);
  check_value(name, expected, data);
endtask

// bit order: lock ref, lock data, loopback, rx ana, rx dig, tx ana, tx dig
task automatic drive_channel_inputs(input logic [6:0] v);
  set_rx_locktoref  = v[0];
  set_rx_locktodata = v[1];
  serial_loopback   = v[2];
  rx_analogreset    = v[3];
  rx_digitalreset   = v[4];
  tx_analogreset    = v[5];
  tx_digitalreset   = v[6];
endtask

// override bit picks the register value, else the input passes through
task automatic check_channel_outputs(input string name, input logic [7:0] lock_b,
                                     input logic [7:0] lpbk_b, input logic [7:0] rst_b);
  logic ltr;
  logic ltd;
  ltr = lock_b[2] ? lock_b[0] : set_rx_locktoref;
  ltd = lock_b[3] ? lock_b[1] : set_rx_locktodata;
  check_value({name, " lock to ref"}, 8'(ltr), 8'(csr_set_lock_to_ref));
  check_value({name, " lock to data"}, 8'(ltd), 8'(csr_set_lock_to_data));
  check_value({name, " loopback"}, 8'(lpbk_b[0] | serial_loopback), 8'(csr_en_loopback));
  check_value({name, " rx ana"}, 8'(rst_b[4] ? rst_b[0] : rx_analogreset),
              8'(csr_rx_analogreset));
  check_value({name, " rx dig"}, 8'(rst_b[5] ? rst_b[1] : rx_digitalreset),
              8'(csr_rx_digitalreset));
  check_value({name, " tx ana"}, 8'(rst_b[6] ? rst_b[2] : tx_analogreset),
              8'(csr_tx_analogreset));
  check_value({name, " tx dig"}, 8'(rst_b[7] ? rst_b[3] : tx_digitalreset),
              8'(csr_tx_digitalreset));
endtask

task automatic test_after_reset();
  logic [7:0] caps [8];
  logic [31:0] rnd;
  caps = '{8'h5a, 8'd1, 8'd1, 8'd1, 8'd0, 8'd3, 8'd1, 8'd0};
  check_value("reset tx mask", 8'd1, 8'(csr_tx_cal_busy_mask));
  check_value("reset rx mask", 8'd1, 8'(csr_rx_cal_busy_mask));
  // both masks set, status inputs all low
  read_expect("reset cal busy", addr_cal_busy, 8'h30);
  read_expect("reset lock status", addr_rd_ltr, 8'h00);
  read_expect("reset lock ctrl", addr_set_ltr, 8'h00);
  read_expect("reset loopback", addr_lpbk, 8'h00);
  read_expect("reset chnl reset", addr_chnl_reset, 8'h00);
  read_expect("reset prbs ctrl", addr_prbs_ctrl, 8'h00);
  check_value("reset prbs en", 8'd0, 8'(prbs_count_en));
  check_value("reset prbs snap", 8'd0, 8'(prbs_snap));
  check_value("reset prbs reset", 8'd0, 8'(prbs_reset));
  for (int i = 0; i < 4; i++) begin
    rnd = $urandom();
    @(negedge avmm_clk);
    drive_channel_inputs(rnd[6:0]);
    @(negedge avmm_clk);
    check_channel_outputs("reset pass through", 8'h00, 8'h00, 8'h00);
  end
  for (int a = 0; a < 8; a++) begin
    read_expect($sformatf("capability %0d", a), csr_addr_width'(a), caps[a]);
  end
  // holes in the map
  read_expect("unmapped 0x008", 10'h008, 8'h00);
  read_expect("unmapped 0x01f", 10'h01f, 8'h00);
  read_expect("unmapped 0x025", 10'h025, 8'h00);
  read_expect("unmapped 0x3ff", 10'h3ff, 8'h00);
endtask

task automatic test_status_sync();
  logic [31:0] rnd;
  logic [7:0]  exp_b;
  for (int i = 0; i < 4; i++) begin
    rnd = $urandom();
    @(negedge avmm_clk);
    rx_is_lockedtoref  = rnd[0];
    rx_is_lockedtodata = rnd[1];
    tx_cal_busy        = rnd[2];
    rx_cal_busy        = rnd[3];
    avmm_busy          = rnd[4];
    // three sync stages plus margin
    repeat (5) @(negedge avmm_clk);
    exp_b = 8'h00;
    exp_b[off_rd_ltr] = rnd[0];
    exp_b[off_rd_ltd] = rnd[1];
    read_expect("status lock", addr_rd_ltr, exp_b);
    exp_b = 8'h30;
    exp_b[off_tx_cal_busy] = rnd[2];
    exp_b[off_rx_cal_busy] = rnd[3];
    exp_b[off_avmm_busy]   = rnd[4];
    read_expect("status cal busy", addr_cal_busy, exp_b);
  end
  @(negedge avmm_clk);
  tx_cal_busy = 1'b0;
  rx_cal_busy = 1'b0;
  avmm_busy   = 1'b0;
  repeat (5) @(negedge avmm_clk);
  for (int i = 0; i < 4; i++) begin
    rnd = $urandom();
    bus_write(addr_cal_busy, rnd[7:0]);
    check_value("mask tx out", 8'(rnd[off_tx_cal_mask]), 8'(csr_tx_cal_busy_mask));
    check_value("mask rx out", 8'(rnd[off_rx_cal_mask]), 8'(csr_rx_cal_busy_mask));
    read_expect("mask readback", addr_cal_busy, rnd[7:0] & 8'h30);
  end
endtask

task automatic test_overrides();
  logic [31:0] rnd;
  logic [31:0] vals;
  for (int i = 0; i < 8; i++) begin
    rnd  = $urandom();
    vals = $urandom();
    @(negedge avmm_clk);
    drive_channel_inputs(rnd[30:24]);
    bus_write(addr_set_ltr, vals[7:0]);
    bus_write(addr_lpbk, vals[15:8]);
    bus_write(addr_chnl_reset, vals[23:16]);
    check_channel_outputs("overrides", vals[7:0], vals[15:8], vals[23:16]);
    read_expect("overrides lock readback", addr_set_ltr, vals[7:0] & 8'h0f);
    read_expect("overrides loopback readback", addr_lpbk, vals[15:8] & 8'h01);
    read_expect("overrides reset readback", addr_chnl_reset, vals[23:16]);
  end
endtask

task automatic test_prbs_ctrl();
  logic [31:0] rnd;
  logic [7:0]  exp_b;
  for (int v = 0; v < 8; v++) begin
    rnd = $urandom();
    @(negedge avmm_clk);
    prbs_done = rnd[8];
    bus_write(addr_prbs_ctrl, {rnd[7:3], 3'(v)});
    check_value("prbs ctrl enable", 8'(v[0]), 8'(prbs_count_en));
    check_value("prbs ctrl reset", 8'(v[1]), 8'(prbs_reset));
    check_value("prbs ctrl snap", 8'(v[2]), 8'(prbs_snap));
    exp_b = 8'(v);
    exp_b[off_prbs_done] = rnd[8];
    read_expect("prbs ctrl readback", addr_prbs_ctrl, exp_b);
  end
  bus_write(addr_prbs_ctrl, 8'h00);
  prbs_done = 1'b0;
endtask

task automatic test_err_clear();
  int wait_cycles;
  check_value("err clear idle", 8'd0, 8'(prbs_reset));
  @(negedge avmm_clk);
  rx_prbs_err_clr = 1'b1;
  wait_cycles = 0;
  while (!prbs_reset && wait_cycles < 5) begin
    @(negedge avmm_clk);
    wait_cycles++;
  end
  check_value("err clear rise", 8'd1, 8'(prbs_reset));
  repeat (3) @(negedge avmm_clk);
  rx_prbs_err_clr = 1'b0;
  wait_cycles = 0;
  while (prbs_reset && wait_cycles < 5) begin
    @(negedge avmm_clk);
    wait_cycles++;
  end
  check_value("err clear fall", 8'd0, 8'(prbs_reset));
  // the clear never lands in the control register
  read_expect("err clear ctrl", addr_prbs_ctrl, 8'h00);
endtask

task automatic test_count_readback();
  logic [63:0] r_err;
  logic [63:0] r_bit;
  logic [7:0]  exp_err;
  logic [7:0]  exp_bit;
  for (int i = 0; i < 3; i++) begin
    r_err = {$urandom(), $urandom()};
    r_bit = {$urandom(), $urandom()};
    @(negedge avmm_clk);
    prbs_err = r_err[count_width-1:0];
    prbs_bit = r_bit[count_width-1:0];
    for (int b = 0; b < count_bytes; b++) begin
      // top byte carries bits 49:48 only
      if (b == count_bytes - 1) begin
        exp_err = {6'b0, r_err[49:48]};
        exp_bit = {6'b0, r_bit[49:48]};
      end else begin
        exp_err = r_err[b*8 +: 8];
        exp_bit = r_bit[b*8 +: 8];
      end
      read_expect($sformatf("err count byte %0d", b),
                  addr_prbs_err_base + csr_addr_width'(b), exp_err);
      read_expect($sformatf("bit count byte %0d", b),
                  addr_prbs_bit_base + csr_addr_width'(b), exp_bit);
    end
  end
endtask

`endif

// ==== tests/tb_xcvr_native_csr.sv ====
`timescale 1ns/1ps

module tb_xcvr_native_csr;

  import xcvr_csr_pkg::*;

  // the directed tests take about 400 cycles, the limit leaves a wide margin
  localparam int timeout_cycles = 3000;
  localparam int reset_cycles   = 4;

  logic                      avmm_clk;
  logic                      avmm_reset;
  logic [csr_addr_width-1:0] avmm_address;
  logic [csr_data_width-1:0] avmm_writedata;
  logic                      avmm_write;
  logic                      avmm_read;
  logic [csr_data_width-1:0] avmm_readdata;
  logic                      avmm_waitrequest;

  // prbs checker side
  logic [count_width-1:0] prbs_err;
  logic [count_width-1:0] prbs_bit;
  logic                   prbs_done;
  logic                   prbs_count_en;
  logic                   prbs_snap;
  logic                   prbs_reset;
  logic                   rx_prbs_err_clr;

  // channel status inputs
  logic rx_is_lockedtodata;
  logic rx_is_lockedtoref;
  logic tx_cal_busy;
  logic rx_cal_busy;
  logic avmm_busy;

  // user side controls
  logic set_rx_locktoref;
  logic set_rx_locktodata;
  logic serial_loopback;
  logic rx_analogreset;
  logic rx_digitalreset;
  logic tx_analogreset;
  logic tx_digitalreset;

  // controls toward the channel
  logic csr_set_lock_to_data;
  logic csr_set_lock_to_ref;
  logic csr_en_loopback;
  logic csr_rx_analogreset;
  logic csr_rx_digitalreset;
  logic csr_tx_analogreset;
  logic csr_tx_digitalreset;
  logic csr_tx_cal_busy_mask;
  logic csr_rx_cal_busy_mask;

  int cycle_count = 0;
  int error_count = 0;

  // every tb signal carries the name of the port it drives or watches
  xcvr_native_csr dut (.*);

  initial begin
    avmm_clk = 1'b0;
  end

  always #5 avmm_clk = ~avmm_clk;

  // stops a hung handshake or poll loop
  always @(posedge avmm_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      report_failure($sformatf("timeout: tests still running after %0d cycles", cycle_count));
    end
  end

  task automatic report_failure(input string why);
    error_count++;
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "stopped at the first error");
  endtask

  `include "tb_csr_tasks.svh"

  initial begin
    void'($urandom(32'hffe2));
    avmm_reset         = 1'b1;
    avmm_address       = '0;
    avmm_writedata     = '0;
    avmm_write         = 1'b0;
    avmm_read          = 1'b0;
    prbs_err           = '0;
    prbs_bit           = '0;
    prbs_done          = 1'b0;
    rx_prbs_err_clr    = 1'b0;
    rx_is_lockedtodata = 1'b0;
    rx_is_lockedtoref  = 1'b0;
    tx_cal_busy        = 1'b0;
    rx_cal_busy        = 1'b0;
    avmm_busy          = 1'b0;
    drive_channel_inputs(7'h00);
    repeat (reset_cycles) @(posedge avmm_clk);
    @(negedge avmm_clk);
    avmm_reset = 1'b0;

    test_after_reset();
    test_status_sync();
    test_overrides();
    test_prbs_ctrl();
    test_err_clear();
    test_count_readback();

    if (error_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      report_failure("errors were counted during the run");
    end
  end

endmodule

// ==== verilog.f ====
+incdir+tests
hw/xcvr_csr_pkg.sv
hw/resync_chain.sv
hw/channel_status_regs.sv
hw/channel_ctrl_regs.sv
hw/prbs_ctrl_regs.sv
hw/csr_read_port.sv
hw/xcvr_native_csr.sv
tests/tb_xcvr_native_csr.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the csr testbench with verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

top=tb_xcvr_native_csr
build_dir=obj_dir

verilator --binary -j 0 -f verilog.f --top-module "$top" -Mdir "$build_dir" -o "V$top"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

"./$build_dir/V$top"
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
